// ==== dec_host.f ====
+incdir+include
rtl/dec_host_pkg.sv
rtl/decode_fsm.sv
rtl/step_counter.sv
rtl/pattern_lfsr.sv
rtl/onehot_decoder.sv
rtl/branch_target_unit.sv
rtl/dec_host_top.sv
verification/dec_host_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the decode host testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f dec_host.f --top-module dec_host_tb -o dec_host_sim \
    > build.log 2>&1 \
    && ./obj_dir/dec_host_sim > sim.log 2>&1 \
    || { cat build.log; echo "Build or simulation error"; exit 1; }

cat sim.log

grep -q "Checks failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "All checks passed" sim.log || { echo "FAIL: no result line"; exit 1; }
echo "PASS"
exit 0

// ==== verification/dec_host_tb.sv ====
// --------------------------------------------------------------------------
// Self-checking testbench for the decode host; random enable and input
// stream, a phase model beside the DUT, and concurrent assertions
// --------------------------------------------------------------------------
`include "dec_host_macros.svh"

module dec_host_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CYCLES     = 400;
    localparam int TIMEOUT_CYCLES = 20 * NUM_CYCLES;

    // DUT signals
    logic                      clk = 1'b0;
    logic                      pon_rst_n;
    logic                      enable;
    logic [`DH_IN_W-1:0]       encoded;
    dec_host_pkg::dec_result_t result;

    // Reference model state
    logic [1:0]           m_phase   = 2'd0;  // Position in the group of four
    logic [`DH_ADR_W-1:0] m_pc      = '0;
    logic [`DH_PAT_W-1:0] m_pat     = `DH_PAT_SEED;
    logic [`DH_OUT_W-1:0] m_dec     = '0;
    logic [`DH_ADR_W-1:0] exp_adr   = '0;
    logic                 exp_valid = 1'b0;
    logic                 prev_en   = 1'b0;  // Enable of the cycle just ended
    int                   en_cnt    = 0;     // Enabled edges since reset up to 3
    int                   en_total  = 0;     // All enabled edges since reset
    logic [3:0]           op_seen   = 4'b0000;

    // Bookkeeping
    logic [31:0] lfsr_state = 32'hdf4b_6975;
    int          err_cnt    = 0;
    int          cov_err    = 0;
    int          pulse_cnt  = 0;
    int          exp_pulses = 0;
    int          cyc_cnt    = 0;

    dec_host_top dut (
        .clk         (clk),
        .pon_rst_n_i (pon_rst_n),
        .enable_i    (enable),
        .encoded_i   (encoded),
        .result_o    (result)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Expected one-hot value for an input code
    function automatic logic [`DH_OUT_W-1:0] onehot_of(input logic [`DH_IN_W-1:0] code);
        if (code >= 8'd16) begin
            return '0;
        end
        return 16'd1 << code[3:0];
    endfunction

    // Expected branch target from program data and pc
    function automatic logic [`DH_ADR_W-1:0] branch_target(input logic [`DH_DAT_W-1:0] dat,
                                                           input logic [`DH_ADR_W-1:0] pc);
        logic [`DH_ADR_W-1:0] ofs;
        ofs = 13'($signed(dat[7:0]));
        case (dec_host_pkg::br_op_e'(dat[13:12]))
            dec_host_pkg::OP_NEXT: return pc + 13'd1;
            dec_host_pkg::OP_SKIP: return pc + 13'd2;
            dec_host_pkg::OP_JUMP: return {pc[12], dat[11:0]};
            default:               return pc + ofs;
        endcase
    endfunction

    // Enable paused about one cycle in eight and half the codes below 16
    task automatic drive_random_cycle();
        logic [31:0] r;
        r = draw_bits(3);
        enable = (r[2:0] != 3'd0);
        if (draw_bits(1) == 32'd1) begin
            encoded = 8'(draw_bits(4));
        end else begin
            encoded = 8'(draw_bits(8));
        end
    endtask

    // Model follows the group, counter and pattern rules edge by edge
    always @(posedge clk or negedge pon_rst_n) begin
        if (!pon_rst_n) begin
            m_phase   <= 2'd0;
            m_pc      <= '0;
            m_pat     <= `DH_PAT_SEED;
            m_dec     <= '0;
            exp_adr   <= '0;
            exp_valid <= 1'b0;
            prev_en   <= 1'b0;
            en_cnt    <= 0;
            en_total  <= 0;
        end else begin
            prev_en   <= enable;
            exp_valid <= 1'b0;
            if (enable) begin
                m_phase  <= m_phase + 2'd1;
                m_pc     <= m_pc + 13'd1;
                m_pat    <= {m_pat[`DH_PAT_W-2:0], m_pat[127] ^ m_pat[95] ^ encoded[0]};
                en_total <= en_total + 1;
                if (en_cnt < 3) begin
                    en_cnt <= en_cnt + 1;
                end
                case (m_phase)
                    2'd0: m_dec <= '0;
                    2'd1: m_dec <= onehot_of(encoded);  // Register was just cleared
                    2'd2: begin
                        exp_valid                <= 1'b1;
                        exp_adr                  <= branch_target(m_pat[`DH_DAT_W-1:0], m_pc);
                        op_seen[m_pat[13:12]]    <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // Checks sample at the falling edge
    a_reset_zero: assert property (@(negedge clk) !pon_rst_n |-> result == '0)
        else begin
            err_cnt++;
            $display("mismatch reset_zero expected %h actual %h", 30'h0, result);
        end

    a_start_dec: assert property (@(negedge clk) (en_cnt < 2) |-> result.decoded == '0)
        else begin
            err_cnt++;
            $display("mismatch start_decoded expected %h actual %h", 16'h0, result.decoded);
        end

    a_start_adr: assert property (@(negedge clk) (en_cnt < 3) |-> result.prog_adr == '0)
        else begin
            err_cnt++;
            $display("mismatch start_address expected %h actual %h", 13'h0, result.prog_adr);
        end

    a_valid_pulse: assert property (@(negedge clk) disable iff (!pon_rst_n)
                                    result.valid == exp_valid)
        else begin
            err_cnt++;
            $display("mismatch valid_pulse expected %b actual %b", exp_valid, result.valid);
        end

    a_valid_phase: assert property (@(negedge clk) disable iff (!pon_rst_n)
                                    result.valid |-> m_phase == 2'd3)
        else begin
            err_cnt++;
            $display("mismatch valid_phase expected %0d actual %0d", 3, m_phase);
        end

    a_valid_paused: assert property (@(negedge clk) disable iff (!pon_rst_n)
                                     !prev_en |-> !result.valid)
        else begin
            err_cnt++;
            $display("mismatch valid_after_pause expected %b actual %b", 1'b0, result.valid);
        end

    a_decoded: assert property (@(negedge clk) disable iff (!pon_rst_n)
                                exp_valid |-> result.decoded == m_dec)
        else begin
            err_cnt++;
            $display("mismatch decoded expected %h actual %h", m_dec, result.decoded);
        end

    a_address: assert property (@(negedge clk) disable iff (!pon_rst_n)
                                exp_valid |-> result.prog_adr == exp_adr)
        else begin
            err_cnt++;
            $display("mismatch address expected %h actual %h", exp_adr, result.prog_adr);
        end

    // Nothing may move while paused
    a_pause_dec: assert property (@(negedge clk) disable iff (!pon_rst_n)
                                  !prev_en |-> result.decoded == m_dec)
        else begin
            err_cnt++;
            $display("mismatch pause_decoded expected %h actual %h", m_dec, result.decoded);
        end

    a_pause_adr: assert property (@(negedge clk) disable iff (!pon_rst_n)
                                  !prev_en |-> result.prog_adr == exp_adr)
        else begin
            err_cnt++;
            $display("mismatch pause_address expected %h actual %h", exp_adr, result.prog_adr);
        end

    always @(negedge clk) begin
        if (pon_rst_n && result.valid) begin
            pulse_cnt <= pulse_cnt + 1;
        end
    end

    // Run limit
    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        pon_rst_n = 1'b0;
        enable    = 1'b0;
        encoded   = '0;
        repeat (3) @(posedge clk);
        #10;
        pon_rst_n = 1'b1;

        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(posedge clk);
            #10;
            drive_random_cycle();
        end

        // Hold the enable until the group in flight presents its result
        @(posedge clk);
        #10;
        enable = 1'b1;
        @(negedge clk);
        while (!result.valid) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);

        // Third edge of every group of four presents
        exp_pulses = (en_total + 1) / 4;
        if (pulse_cnt != exp_pulses) begin
            err_cnt++;
            $display("mismatch pulse_count expected %0d actual %0d", exp_pulses, pulse_cnt);
        end

        if (op_seen != 4'b1111) begin
            cov_err++;
            $display("not every branch opcode was exercised, seen mask %b", op_seen);
        end

        $display("summary: %0d valid pulses, %0d assertion errors, %0d coverage errors",
                 pulse_cnt, err_cnt, cov_err);
        if (err_cnt == 0 && cov_err == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== rtl/dec_host_top.sv ====
// --------------------------------------------------------------------------
// Decode host top level; wires the sequencer, counter, pattern register,
// decoder and branch target unit into one result bundle
// --------------------------------------------------------------------------
`include "dec_host_macros.svh"

module dec_host_top (
    input  logic                      clk,
    input  logic                      pon_rst_n_i,
    input  logic                      enable_i,
    input  logic [`DH_IN_W-1:0]       encoded_i,
    output dec_host_pkg::dec_result_t result_o
);

    dec_host_pkg::dec_ctrl_t ctrl;
    logic [`DH_ADR_W-1:0]    pc;
    logic [`DH_PAT_W-1:0]    pattern;
    logic [`DH_DAT_W-1:0]    prog_dat;
    logic [`DH_OUT_W-1:0]    decoded;
    logic [`DH_ADR_W-1:0]    prog_adr;
    logic                    valid;

    assign prog_dat = pattern[`DH_DAT_W-1:0];  // Low bits act as program data

    decode_fsm u_fsm (
        .clk         (clk),
        .pon_rst_n_i (pon_rst_n_i),
        .enable_i    (enable_i),
        .ctrl_o      (ctrl)
    );

    step_counter u_pc (
        .clk         (clk),
        .pon_rst_n_i (pon_rst_n_i),
        .enable_i    (enable_i),
        .pc_o        (pc)
    );

    pattern_lfsr u_pattern (
        .clk         (clk),
        .pon_rst_n_i (pon_rst_n_i),
        .enable_i    (enable_i),
        .feed_i      (encoded_i[0]),
        .pattern_o   (pattern)
    );

    onehot_decoder u_decoder (
        .clk         (clk),
        .pon_rst_n_i (pon_rst_n_i),
        .ctrl_i      (ctrl),
        .encoded_i   (encoded_i),
        .decoded_o   (decoded),
        .valid_o     (valid)
    );

    branch_target_unit u_branch (
        .clk         (clk),
        .pon_rst_n_i (pon_rst_n_i),
        .ctrl_i      (ctrl),
        .prog_dat_i  (prog_dat),
        .pc_i        (pc),
        .prog_adr_o  (prog_adr)
    );

    // Pack the outputs
    assign result_o.decoded  = decoded;
    assign result_o.prog_adr = prog_adr;
    assign result_o.valid    = valid;

endmodule

// ==== rtl/branch_target_unit.sv ====
// --------------------------------------------------------------------------
// Branch target unit; decodes the opcode in the program data, computes the
// next address from pc and captures it when the result is presented
// --------------------------------------------------------------------------
`include "dec_host_macros.svh"

module branch_target_unit (
    input  logic                    clk,
    input  logic                    pon_rst_n_i,
    input  dec_host_pkg::dec_ctrl_t ctrl_i,
    input  logic [`DH_DAT_W-1:0]    prog_dat_i,
    input  logic [`DH_ADR_W-1:0]    pc_i,
    output logic [`DH_ADR_W-1:0]    prog_adr_o
);

    dec_host_pkg::br_op_e op;
    logic [`DH_ADR_W-1:0] rel_ofs;
    logic [`DH_ADR_W-1:0] target;
    logic [`DH_ADR_W-1:0] adr_q;

    assign op = dec_host_pkg::br_op_e'(prog_dat_i[13:12]);

    // Signed 8-bit displacement widened to address width
    assign rel_ofs = {{(`DH_ADR_W-8){prog_dat_i[7]}}, prog_dat_i[7:0]};

    always_comb begin
        case (op)
            dec_host_pkg::OP_NEXT: target = pc_i + `DH_ADR_W'd1;
            dec_host_pkg::OP_SKIP: target = pc_i + `DH_ADR_W'd2;
            dec_host_pkg::OP_JUMP: target = {pc_i[12], prog_dat_i[11:0]};  // Stays in page
            default:               target = pc_i + rel_ofs;
        endcase
    end

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            adr_q <= '0;
        end else if (ctrl_i.present) begin
            adr_q <= target;
        end
    end

    assign prog_adr_o = adr_q;

endmodule

// ==== rtl/onehot_decoder.sv ====
// --------------------------------------------------------------------------
// One-hot result register and valid pulse, driven by the sequencer controls
// --------------------------------------------------------------------------
`include "dec_host_macros.svh"

module onehot_decoder (
    input  logic                    clk,
    input  logic                    pon_rst_n_i,
    input  dec_host_pkg::dec_ctrl_t ctrl_i,
    input  logic [`DH_IN_W-1:0]     encoded_i,
    output logic [`DH_OUT_W-1:0]    decoded_o,
    output logic                    valid_o
);

    logic [`DH_OUT_W-1:0] dec_q;
    logic                 valid_q;
    logic                 in_range;

    // Codes of 16 and up leave the result empty
    assign in_range = (encoded_i < `DH_IN_W'(`DH_OUT_W));

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            dec_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            if (ctrl_i.clear) begin
                dec_q <= '0;
            end else if (ctrl_i.set && in_range) begin
                dec_q[encoded_i[3:0]] <= 1'b1;
            end
            valid_q <= ctrl_i.present;  // Drops on every other edge
        end
    end

    assign decoded_o = dec_q;
    assign valid_o   = valid_q;

endmodule

// ==== rtl/pattern_lfsr.sv ====
// --------------------------------------------------------------------------
// 128-bit pattern register; shifts left on enable and folds feed_i into
// the feedback tap so the input stream stirs the program data
// --------------------------------------------------------------------------
`include "dec_host_macros.svh"

module pattern_lfsr (
    input  logic                 clk,
    input  logic                 pon_rst_n_i,
    input  logic                 enable_i,
    input  logic                 feed_i,
    output logic [`DH_PAT_W-1:0] pattern_o
);

    logic [`DH_PAT_W-1:0] pat_q;
    logic                 fb;

    // Taps at bits 127 and 95, plus the external bit
    assign fb = pat_q[`DH_PAT_W-1] ^ pat_q[95] ^ feed_i;

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            pat_q <= `DH_PAT_SEED;
        end else if (enable_i) begin
            pat_q <= {pat_q[`DH_PAT_W-2:0], fb};
        end
    end

    assign pattern_o = pat_q;

endmodule

// ==== rtl/step_counter.sv ====
// --------------------------------------------------------------------------
// Program counter; advances on each enabled cycle and wraps at full width
// --------------------------------------------------------------------------
`include "dec_host_macros.svh"

module step_counter (
    input  logic                 clk,
    input  logic                 pon_rst_n_i,
    input  logic                 enable_i,
    output logic [`DH_ADR_W-1:0] pc_o
);

    logic [`DH_ADR_W-1:0] pc_q;

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            pc_q <= '0;
        end else if (enable_i) begin
            pc_q <= pc_q + `DH_ADR_W'd1;  // Natural wrap
        end
    end

    assign pc_o = pc_q;

endmodule

// ==== rtl/decode_fsm.sv ====
// --------------------------------------------------------------------------
// Four-phase decode sequencer; steps once per enabled cycle and decodes
// its state into the clear, set and present controls
// --------------------------------------------------------------------------
module decode_fsm (
    input  logic                   clk,
    input  logic                   pon_rst_n_i,
    input  logic                   enable_i,
    output dec_host_pkg::dec_ctrl_t ctrl_o
);

    dec_host_pkg::dec_state_e state_q;
    dec_host_pkg::dec_state_e state_d;

    // Next phase in the fixed cycle
    always_comb begin
        case (state_q)
            dec_host_pkg::ST_CLEAR:   state_d = dec_host_pkg::ST_DECODE;
            dec_host_pkg::ST_DECODE:  state_d = dec_host_pkg::ST_PRESENT;
            dec_host_pkg::ST_PRESENT: state_d = dec_host_pkg::ST_WAIT;
            default:                  state_d = dec_host_pkg::ST_CLEAR;
        endcase
    end

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            state_q <= dec_host_pkg::ST_CLEAR;
        end else if (enable_i) begin
            state_q <= state_d;
        end
        // Held while the enable is low
    end

    // Controls only fire in an enabled cycle of the matching phase
    always_comb begin
        ctrl_o         = '0;
        ctrl_o.clear   = enable_i && (state_q == dec_host_pkg::ST_CLEAR);
        ctrl_o.set     = enable_i && (state_q == dec_host_pkg::ST_DECODE);
        ctrl_o.present = enable_i && (state_q == dec_host_pkg::ST_PRESENT);
    end

endmodule

// ==== rtl/dec_host_pkg.sv ====
// --------------------------------------------------------------------------
// Shared types of the decode host: sequencer states, branch opcodes, buses
// --------------------------------------------------------------------------
`include "dec_host_macros.svh"

package dec_host_pkg;

    // Decode sequencer phases, one per enabled cycle
    typedef enum logic [1:0] {
        ST_CLEAR   = 2'd0,
        ST_DECODE  = 2'd1,
        ST_PRESENT = 2'd2,
        ST_WAIT    = 2'd3
    } dec_state_e;

    // Branch opcode, program data bits 13:12
    typedef enum logic [1:0] {
        OP_NEXT = 2'd0,
        OP_SKIP = 2'd1,
        OP_JUMP = 2'd2,
        OP_REL  = 2'd3
    } br_op_e;

    // Sequencer controls, each valid for one enabled cycle
    typedef struct packed {
        logic clear;
        logic set;
        logic present;
    } dec_ctrl_t;

    // Top-level result bundle
    typedef struct packed {
        logic [`DH_OUT_W-1:0] decoded;
        logic [`DH_ADR_W-1:0] prog_adr;
        logic                 valid;   // One-cycle pulse
    } dec_result_t;

endpackage

// ==== include/dec_host_macros.svh ====
// --------------------------------------------------------------------------
// Width and seed constants for the decode host; include before using them
// --------------------------------------------------------------------------
`ifndef DEC_HOST_MACROS_SVH
`define DEC_HOST_MACROS_SVH

// Datapath widths
`define DH_IN_W  8
`define DH_OUT_W 16
`define DH_ADR_W 13  // Program address and pc
`define DH_DAT_W 14
`define DH_PAT_W 128

// Pattern register reset value
`define DH_PAT_SEED 128'hFEDC_BA98_7654_3210_FEDC_BA98_7654_3210

`endif
